//--- ovi_mem_top.f
rtl/ovi_pkg.sv
rtl/ovi_memop_ctrl.sv
rtl/ovi_load_compact.sv
rtl/ovi_load_merge.sv
rtl/ovi_store_pack.sv
rtl/ovi_mem_top.sv
dv/ovi_mem_checker.sv
dv/ovi_mem_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the ovi_mem testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module ovi_mem_tb \
  -f ovi_mem_top.f -o ovi_mem_sim \
  && ./obj_dir/ovi_mem_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Test passed" sim.log && echo "simulation PASS" && exit 0 \
  || { echo "simulation FAIL"; exit 1; }

//--- dv/ovi_mem_tb.sv
`timescale 1ns/100ps

module ovi_mem_tb;

  logic               clk;
  logic               reset_n;
  logic               issue_valid;
  logic [31:0]        issue_inst;
  ovi_pkg::sb_id_t    issue_sb_id;
  ovi_pkg::stride_t   issue_opnd;
  logic               issue_ready;
  logic               load_valid;
  ovi_pkg::seq_id_t   load_seq_id;
  ovi_pkg::beat_t     load_data;
  logic               st_valid;
  ovi_pkg::vreg_t     st_data;
  logic               st_last;
  logic               st_ready;
  logic               store_valid;
  ovi_pkg::beat_t     store_data;
  logic               store_credit;
  logic               sync_end;
  logic               sync_start;
  logic               completed_valid;
  ovi_pkg::sb_id_t    completed_sb_id;
  ovi_pkg::vreg_idx_t rd_vreg;
  ovi_pkg::vreg_t     rd_data;

  // models of the load buffer and of the expected store beats
  ovi_pkg::vreg_t regs_model [ovi_pkg::NUM_VREGS];
  ovi_pkg::beat_t exp_beats [$];
  ovi_pkg::vreg_t half_reg;
  logic           have_half;
  logic           rd_check;
  int             cur_eew;
  longint         cur_stride;
  int             seed;
  int             errors;
  int             err_mark;
  int             beats_seen;
  int             tests_run;
  int             tests_failed;

  ovi_mem_top #(.STORE_CREDITS(4)) UUT (
    .clk (clk), .reset_n (reset_n),
    .i_issue_valid (issue_valid), .i_issue_inst (issue_inst),
    .i_issue_sb_id (issue_sb_id), .i_issue_scalar_opnd (issue_opnd),
    .o_issue_ready (issue_ready),
    .i_load_valid (load_valid), .i_load_seq_id (load_seq_id), .i_load_data (load_data),
    .i_st_valid (st_valid), .i_st_data (st_data), .i_st_last (st_last),
    .o_st_ready (st_ready),
    .o_store_valid (store_valid), .o_store_data (store_data), .i_store_credit (store_credit),
    .i_memop_sync_end (sync_end), .o_memop_sync_start (sync_start),
    .o_completed_valid (completed_valid), .o_completed_sb_id (completed_sb_id),
    .i_rd_vreg (rd_vreg), .o_rd_data (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // element i comes from i*r + off, or from the top for a negative stride
  function automatic ovi_pkg::beat_t ref_compact(input ovi_pkg::beat_t din, input int eew,
                                                 input longint stride, input int el_off);
    longint         e_bytes;
    longint         mag;
    int             ebits;
    int             n;
    int             r;
    int             src;
    ovi_pkg::beat_t res;
    e_bytes = longint'(1) << eew;
    mag     = (stride < 0) ? -stride : stride;
    ebits   = 8 << eew;
    n       = 512 / ebits;
    if (mag == e_bytes)
      r = 1;
    else if (mag == 2 * e_bytes)
      r = 2;
    else if (mag == 4 * e_bytes)
      r = 4;
    else
      return din;
    res = '0;
    for (int i = 0; i < n / r; i++) begin
      if (stride > 0)
        src = i * r + el_off % r;
      else
        src = n - 1 - i * r - el_off % r;
      for (int b = 0; b < ebits; b++)
        res[i * ebits + b] = din[src * ebits + b];
    end
    return res;
  endfunction

  function automatic ovi_pkg::vreg_t ref_merge(input ovi_pkg::vreg_t old, input ovi_pkg::beat_t pk,
                                               input int eew, input int el_id, input int el_cnt);
    int             ebits;
    ovi_pkg::vreg_t res;
    ebits = 8 << eew;
    res   = old;
    for (int m = 0; m < el_cnt; m++) begin
      // elements past the register end are dropped
      if ((el_id + m + 1) * ebits <= 256)
        for (int b = 0; b < ebits; b++)
          res[(el_id + m) * ebits + b] = pk[m * ebits + b];
    end
    return res;
  endfunction

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // compare process samples at the falling edge where outputs are settled
  always @(negedge clk) begin
    ovi_pkg::beat_t exp;
    if (store_valid) begin
      beats_seen++;
      assert (exp_beats.size() != 0)
        else begin
          $display("store beat arrived while no beat was expected");
          errors++;
        end
      if (exp_beats.size() != 0) begin
        exp = exp_beats.pop_front();
        assert (store_data == exp)
          else begin
            $display("[FAIL] o_store_data: got %h expected %h", store_data, exp);
            errors++;
          end
      end
    end
    if (rd_check)
      assert (rd_data == regs_model[rd_vreg])
        else begin
          $display("[FAIL] o_rd_data: got %h expected %h", rd_data, regs_model[rd_vreg]);
          errors++;
        end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic close_test(input string name);
    tests_run++;
    if (errors != err_mark)
      tests_failed++;
    $display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
    err_mark = errors;
  endtask

  task automatic issue_op(input logic [6:0] opc, input int eew, input longint stride,
                          input int sb);
    logic [2:0] f3;
    int         n;
    n = 0;
    @(negedge clk);
    while (!issue_ready && n < 100) begin
      @(negedge clk);
      n++;
    end
    assert (issue_ready)
      else begin
        $display("timed out waiting for the DUT to accept an issue");
        errors++;
      end
    case (eew)
      0:       f3 = 3'b000;
      1:       f3 = 3'b101;
      2:       f3 = 3'b110;
      default: f3 = 3'b111;
    endcase
    next_cycle();
    issue_valid = 1'b1;
    issue_inst  = {17'd0, f3, 5'd0, opc};
    issue_sb_id = ovi_pkg::sb_id_t'(sb);
    issue_opnd  = ovi_pkg::stride_t'(stride);
    next_cycle();
    issue_valid = 1'b0;
    cur_eew     = eew;
    cur_stride  = stride;
    @(negedge clk);
    assert (sync_start)
      else begin
        $display("[FAIL] o_memop_sync_start: got %h expected 1", sync_start);
        errors++;
      end
    next_cycle();
  endtask

  // exp_wait counts cycles from sync end to completion, and 0 accepts any count
  task automatic end_op(input int sb, input int exp_wait);
    int n;
    sync_end = 1'b1;
    next_cycle();
    sync_end = 1'b0;
    n = 1;
    @(negedge clk);
    while (!completed_valid && n < 100) begin
      @(negedge clk);
      n++;
    end
    assert (completed_valid)
      else begin
        $display("timed out waiting for the op to complete");
        errors++;
      end
    assert (completed_sb_id == ovi_pkg::sb_id_t'(sb))
      else begin
        $display("[FAIL] o_completed_sb_id: got %h expected %h", completed_sb_id, sb);
        errors++;
      end
    assert (exp_wait == 0 || n == exp_wait)
      else begin
        $display("op completed %0d cycles after sync end instead of %0d", n, exp_wait);
        errors++;
      end
    assert (exp_beats.size() == 0)
      else begin
        $display("op completed while store beats were still outstanding");
        errors++;
      end
    next_cycle();
  endtask

  task automatic load_beat(input int vreg, input int el_id, input int el_off, input int el_cnt);
    ovi_pkg::beat_t   data;
    ovi_pkg::seq_id_t seq;
    for (int k = 0; k < 16; k++)
      data[k*32 +: 32] = $random(seed);
    seq = '0;
    seq[ovi_pkg::SEQ_VREG_LSB  +: 3]  = 3'(vreg);
    seq[ovi_pkg::SEQ_ELID_LSB  +: 11] = 11'(el_id);
    seq[ovi_pkg::SEQ_ELOFF_LSB +: 6]  = 6'(el_off);
    seq[ovi_pkg::SEQ_ELCNT_LSB +: 7]  = 7'(el_cnt);
    next_cycle();
    load_valid  = 1'b1;
    load_seq_id = seq;
    load_data   = data;
    next_cycle();
    load_valid = 1'b0;
    regs_model[vreg] = ref_merge(regs_model[vreg],
                                 ref_compact(data, cur_eew, cur_stride, el_off),
                                 cur_eew, el_id, el_cnt);
    rd_vreg  = ovi_pkg::vreg_idx_t'(vreg);
    rd_check = 1'b1;
    next_cycle();
    rd_check = 1'b0;
  endtask

  // one register per cycle with st_last on the final one
  task automatic store_regs(input int num);
    ovi_pkg::vreg_t data;
    int             n;
    for (int r = 0; r < num; r++) begin
      for (int k = 0; k < 8; k++)
        data[k*32 +: 32] = $random(seed);
      st_valid = 1'b1;
      st_data  = data;
      st_last  = (r == num - 1);
      n = 0;
      @(negedge clk);
      while (!st_ready && n < 100) begin
        @(negedge clk);
        n++;
      end
      assert (st_ready)
        else begin
          $display("timed out waiting for store buffer space");
          errors++;
        end
      // older register goes in the low half and a lone last one is padded with zero
      if (have_half) begin
        exp_beats.push_back({data, half_reg});
        have_half = 1'b0;
      end else if (r == num - 1) begin
        exp_beats.push_back({256'd0, data});
      end else begin
        half_reg  = data;
        have_half = 1'b1;
      end
      next_cycle();
    end
    st_valid = 1'b0;
    st_last  = 1'b0;
  endtask

  task automatic wait_beats(input int target);
    int n;
    n = 0;
    while (beats_seen < target && n < 200) begin
      next_cycle();
      n++;
    end
    assert (beats_seen >= target)
      else begin
        $display("timed out waiting for store beats, %0d of %0d seen", beats_seen, target);
        errors++;
      end
  endtask

  task automatic return_credits(input int num);
    for (int c = 0; c < num; c++) begin
      store_credit = 1'b1;
      next_cycle();
      store_credit = 1'b0;
      next_cycle();
    end
  endtask

  initial begin
    longint stride;
    int     sb;
    int     base;
    seed = 22;
    errors = 0;
    err_mark = 0;
    beats_seen = 0;
    tests_run = 0;
    tests_failed = 0;
    have_half = 1'b0;
    half_reg = '0;
    rd_check = 1'b0;
    cur_eew = 0;
    cur_stride = 1;
    sb = 1;
    for (int v = 0; v < ovi_pkg::NUM_VREGS; v++)
      regs_model[v] = '0;
    reset_n = 1'b0;
    issue_valid = 1'b0;
    issue_inst = '0;
    issue_sb_id = '0;
    issue_opnd = '0;
    load_valid = 1'b0;
    load_seq_id = '0;
    load_data = '0;
    st_valid = 1'b0;
    st_data = '0;
    st_last = 1'b0;
    store_credit = 1'b0;
    sync_end = 1'b0;
    rd_vreg = '0;
    repeat (4) @(posedge clk);
    #1;
    reset_n = 1'b1;
    next_cycle();

    assert (!store_valid)
      else begin
        $display("[FAIL] o_store_valid: got %h expected 0", store_valid);
        errors++;
      end
    assert (!sync_start)
      else begin
        $display("[FAIL] o_memop_sync_start: got %h expected 0", sync_start);
        errors++;
      end
    assert (!completed_valid)
      else begin
        $display("[FAIL] o_completed_valid: got %h expected 0", completed_valid);
        errors++;
      end
    assert (issue_ready)
      else begin
        $display("[FAIL] o_issue_ready: got %h expected 1", issue_ready);
        errors++;
      end
    for (int v = 0; v < ovi_pkg::NUM_VREGS; v++) begin
      rd_vreg  = ovi_pkg::vreg_idx_t'(v);
      rd_check = 1'b1;
      next_cycle();
    end
    rd_check = 1'b0;
    close_test("reset state");

    for (int e = 0; e < 4; e++) begin
      issue_op(ovi_pkg::OPC_VLOAD, e, longint'(1) << e, sb);
      for (int b = 0; b < 6; b++)
        load_beat(rand_below(8), rand_below((32 >> e) + 4), 0, 1 + rand_below(64 >> e));
      end_op(sb, 1);
      sb++;
    end
    close_test("unit-stride loads");

    for (int e = 0; e < 4; e++) begin
      for (int r = 2; r <= 4; r += 2) begin
        for (int s = 0; s < 2; s++) begin
          stride = (s == 0) ? (longint'(r) << e) : -(longint'(r) << e);
          issue_op(ovi_pkg::OPC_VLOAD, e, stride, sb);
          for (int b = 0; b < 3; b++)
            load_beat(rand_below(8), rand_below(32 >> e), rand_below(64),
                      1 + rand_below(64 >> e));
          end_op(sb, 1);
          sb = (sb + 1) % 32;
        end
      end
    end
    close_test("strided loads");

    base = beats_seen;
    issue_op(ovi_pkg::OPC_VSTORE, 3, 8, sb);
    store_regs(5);
    wait_beats(base + 3);
    end_op(sb, 1);
    return_credits(3);
    close_test("store pairing");

    base = beats_seen;
    sb = (sb + 1) % 32;
    issue_op(ovi_pkg::OPC_VSTORE, 3, 8, sb);
    store_regs(16);
    wait_beats(base + 4);
    // no credit comes back, so the count must stay put
    repeat (6) next_cycle();
    assert (beats_seen == base + 4)
      else begin
        $display("[FAIL] store beat count: got %h expected %h", beats_seen - base, 4);
        errors++;
      end
    assert (!st_ready)
      else begin
        $display("[FAIL] o_st_ready: got %h expected 0", st_ready);
        errors++;
      end
    return_credits(4);
    wait_beats(base + 8);
    end_op(sb, 1);
    return_credits(4);
    close_test("credit back-pressure");

    sb = 27;
    issue_op(ovi_pkg::OPC_VLOAD, 2, 4, sb);
    load_beat(rand_below(8), rand_below(8), 0, 1 + rand_below(16));
    end_op(sb, 1);
    sb = 19;
    issue_op(ovi_pkg::OPC_VSTORE, 3, 8, sb);
    store_regs(4);
    // sync end lands while the last pair is still buffered
    end_op(sb, 2);
    return_credits(2);
    close_test("sync and completion");

    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- dv/ovi_mem_checker.sv
`timescale 1ns/100ps

module ovi_mem_checker #(
  parameter int MAX_OUTSTANDING = 4
) (
  input logic clk,
  input logic reset_n,
  input logic i_issue_valid,
  input logic i_issue_ready,
  input logic i_sync_start,
  input logic i_completed_valid,
  input logic i_store_valid,
  input logic i_store_credit
);

  // beats sent minus credits returned so far
  int outstanding;

  always_ff @(posedge clk) begin
    if (!reset_n)
      outstanding <= 0;
    else
      outstanding <= outstanding + int'(i_store_valid) - int'(i_store_credit);
  end

  a_sync_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    i_sync_start |=> !i_sync_start)
    else $error("memop sync start held for more than one cycle");

  a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    i_completed_valid |=> !i_completed_valid)
    else $error("completion held for more than one cycle");

  a_credit_limit: assert property (@(posedge clk) disable iff (!reset_n)
    i_store_valid |-> (outstanding < MAX_OUTSTANDING))
    else $error("store beat sent without a free credit");

  // busy from acceptance, ready again only together with completion
  a_busy: assert property (@(posedge clk) disable iff (!reset_n)
    (i_issue_valid && i_issue_ready) |=> !i_issue_ready)
    else $error("issue ready stayed high after an accepted op");

  a_ready_rise: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(i_issue_ready) |-> i_completed_valid)
    else $error("issue ready rose without a completion");

endmodule

bind ovi_mem_top ovi_mem_checker u_checker (
  .clk               (clk),
  .reset_n           (reset_n),
  .i_issue_valid     (i_issue_valid),
  .i_issue_ready     (o_issue_ready),
  .i_sync_start      (o_memop_sync_start),
  .i_completed_valid (o_completed_valid),
  .i_store_valid     (o_store_valid),
  .i_store_credit    (i_store_credit)
);

//--- rtl/ovi_mem_top.sv
`timescale 1ns/100ps

module ovi_mem_top #(
  parameter int STORE_CREDITS = 32,
  parameter int SB_DEPTH      = 8
) (
  input  logic               clk,
  input  logic               reset_n,
  // issue
  input  logic               i_issue_valid,
  input  logic [31:0]        i_issue_inst,
  input  ovi_pkg::sb_id_t    i_issue_sb_id,
  input  ovi_pkg::stride_t   i_issue_scalar_opnd,
  output logic               o_issue_ready,
  // load return
  input  logic               i_load_valid,
  input  ovi_pkg::seq_id_t   i_load_seq_id,
  input  ovi_pkg::beat_t     i_load_data,
  // store source from the vector core
  input  logic               i_st_valid,
  input  ovi_pkg::vreg_t     i_st_data,
  input  logic               i_st_last,
  output logic               o_st_ready,
  // store beats to memory
  output logic               o_store_valid,
  output ovi_pkg::beat_t     o_store_data,
  input  logic               i_store_credit,
  // sync and completion
  input  logic               i_memop_sync_end,
  output logic               o_memop_sync_start,
  output logic               o_completed_valid,
  output ovi_pkg::sb_id_t    o_completed_sb_id,
  // load buffer read port
  input  ovi_pkg::vreg_idx_t i_rd_vreg,
  output ovi_pkg::vreg_t     o_rd_data
);

  ovi_pkg::eew_t    eew;
  ovi_pkg::stride_t stride;
  logic             drained;

  ovi_memop_ctrl u_ctrl (
    .clk                 (clk),
    .reset_n             (reset_n),
    .i_issue_valid       (i_issue_valid),
    .i_issue_inst        (i_issue_inst),
    .i_issue_sb_id       (i_issue_sb_id),
    .i_issue_scalar_opnd (i_issue_scalar_opnd),
    .i_memop_sync_end    (i_memop_sync_end),
    .i_drained           (drained),
    .o_issue_ready       (o_issue_ready),
    .o_memop_sync_start  (o_memop_sync_start),
    .o_completed_valid   (o_completed_valid),
    .o_completed_sb_id   (o_completed_sb_id),
    .o_eew               (eew),
    .o_stride            (stride)
  );

  ovi_load_merge u_load (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_load_valid  (i_load_valid),
    .i_load_seq_id (i_load_seq_id),
    .i_load_data   (i_load_data),
    .i_eew         (eew),
    .i_stride      (stride),
    .i_rd_vreg     (i_rd_vreg),
    .o_rd_data     (o_rd_data)
  );

  ovi_store_pack #(
    .STORE_CREDITS (STORE_CREDITS),
    .SB_DEPTH      (SB_DEPTH)
  ) u_store (
    .clk            (clk),
    .reset_n        (reset_n),
    .i_st_valid     (i_st_valid),
    .i_st_data      (i_st_data),
    .i_st_last      (i_st_last),
    .i_store_credit (i_store_credit),
    .o_st_ready     (o_st_ready),
    .o_drained      (drained),
    .o_store_valid  (o_store_valid),
    .o_store_data   (o_store_data)
  );

endmodule

//--- rtl/ovi_store_pack.sv
`timescale 1ns/100ps

module ovi_store_pack #(
  parameter int STORE_CREDITS = 32,
  parameter int SB_DEPTH      = 8
) (
  input  logic           clk,
  input  logic           reset_n,
  input  logic           i_st_valid,
  input  ovi_pkg::vreg_t i_st_data,
  input  logic           i_st_last,
  input  logic           i_store_credit,
  output logic           o_st_ready,
  output logic           o_drained,
  output logic           o_store_valid,
  output ovi_pkg::beat_t o_store_data
);

  localparam int PTR_W  = $clog2(SB_DEPTH);
  localparam int CRED_W = $clog2(STORE_CREDITS + 1);

  ovi_pkg::vreg_t    sb_mem [SB_DEPTH];
  logic [PTR_W:0]    wptr;
  logic [PTR_W:0]    rptr;
  logic [PTR_W:0]    count;
  logic [PTR_W:0]    count_nxt;
  logic [PTR_W:0]    rd_num;
  logic [PTR_W-1:0]  rd_idx;
  logic [PTR_W-1:0]  rd_idx_nxt;
  logic [CRED_W-1:0] credits;
  logic              flush;
  logic              st_wr;
  logic              send_pair;
  logic              send_single;
  logic              send;

  // pointers carry a wrap bit so full and empty differ
  assign count      = wptr - rptr;
  assign o_st_ready = (count != (PTR_W+1)'(SB_DEPTH));
  assign o_drained  = (count == '0);
  assign st_wr      = i_st_valid && o_st_ready;

  assign rd_idx     = rptr[PTR_W-1:0];
  assign rd_idx_nxt = rd_idx + 1'b1;

  // a lone entry only goes out once the last register was written
  assign send_pair   = (count >= (PTR_W+1)'(2)) && (credits != '0);
  assign send_single = flush && (count == (PTR_W+1)'(1)) && (credits != '0);
  assign send        = send_pair || send_single;
  assign rd_num      = (PTR_W+1)'({send_pair, send_single});
  assign count_nxt   = count + (PTR_W+1)'(st_wr) - rd_num;

  always_ff @(posedge clk) begin
    if (st_wr)
      sb_mem[wptr[PTR_W-1:0]] <= i_st_data;
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wptr          <= '0;
      rptr          <= '0;
      flush         <= 1'b0;
      o_store_valid <= 1'b0;
      credits       <= CRED_W'(STORE_CREDITS);
    end else begin
      if (st_wr)
        wptr <= wptr + 1'b1;
      rptr          <= rptr + rd_num;
      o_store_valid <= send;
      credits       <= credits - CRED_W'(send) + CRED_W'(i_store_credit);
      if (st_wr && i_st_last)
        flush <= 1'b1;
      else if (count_nxt == '0)
        flush <= 1'b0;
    end
  end

  // older entry in the low half, newer in the high half
  always_ff @(posedge clk) begin
    if (send) begin
      o_store_data[ovi_pkg::VLEN-1:0] <= sb_mem[rd_idx];
      o_store_data[ovi_pkg::BEAT_W-1:ovi_pkg::VLEN] <= send_pair ? sb_mem[rd_idx_nxt] : '0;
    end
  end

endmodule

//--- rtl/ovi_load_merge.sv
`timescale 1ns/100ps

module ovi_load_merge (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               i_load_valid,
  input  ovi_pkg::seq_id_t   i_load_seq_id,
  input  ovi_pkg::beat_t     i_load_data,
  input  ovi_pkg::eew_t      i_eew,
  input  ovi_pkg::stride_t   i_stride,
  input  ovi_pkg::vreg_idx_t i_rd_vreg,
  output ovi_pkg::vreg_t     o_rd_data
);

  ovi_pkg::vreg_idx_t vreg;
  ovi_pkg::el_idx_t   el_id;
  ovi_pkg::el_off_t   el_off;
  ovi_pkg::el_cnt_t   el_cnt;
  ovi_pkg::beat_t     packed_data;
  ovi_pkg::beat_t     shifted;
  ovi_pkg::vreg_t     wr_mask;
  ovi_pkg::vreg_t     load_buf [ovi_pkg::NUM_VREGS];
  logic [31:0]        lo_bit;
  logic [31:0]        hi_bit;

  assign vreg   = i_load_seq_id[ovi_pkg::SEQ_VREG_LSB  +: $bits(ovi_pkg::vreg_idx_t)];
  assign el_id  = i_load_seq_id[ovi_pkg::SEQ_ELID_LSB  +: $bits(ovi_pkg::el_idx_t)];
  assign el_off = i_load_seq_id[ovi_pkg::SEQ_ELOFF_LSB +: $bits(ovi_pkg::el_off_t)];
  assign el_cnt = i_load_seq_id[ovi_pkg::SEQ_ELCNT_LSB +: $bits(ovi_pkg::el_cnt_t)];

  ovi_load_compact u_compact (
    .i_load_data (i_load_data),
    .i_eew       (i_eew),
    .i_stride    (i_stride),
    .i_el_off    (el_off),
    .o_packed    (packed_data)
  );

  // bit window covered by elements el_id .. el_id+el_cnt-1
  assign lo_bit  = 32'(el_id) << (3 + i_eew);
  assign hi_bit  = (32'(el_id) + 32'(el_cnt)) << (3 + i_eew);
  assign shifted = packed_data << lo_bit;

  // bits at or past VLEN simply fall off the register
  always_comb begin
    for (int k = 0; k < ovi_pkg::VLEN; k++)
      wr_mask[k] = (k >= lo_bit) && (k < hi_bit);
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      for (int v = 0; v < ovi_pkg::NUM_VREGS; v++)
        load_buf[v] <= '0;
    end else if (i_load_valid) begin
      load_buf[vreg] <= (load_buf[vreg] & ~wr_mask) |
                        (shifted[ovi_pkg::VLEN-1:0] & wr_mask);
    end
  end

  assign o_rd_data = load_buf[i_rd_vreg];

endmodule

//--- rtl/ovi_load_compact.sv
`timescale 1ns/100ps

module ovi_load_compact (
  input  ovi_pkg::beat_t   i_load_data,
  input  ovi_pkg::eew_t    i_eew,
  input  ovi_pkg::stride_t i_stride,
  input  ovi_pkg::el_off_t i_el_off,
  output ovi_pkg::beat_t   o_packed
);

  localparam int BEAT_BYTES = ovi_pkg::BEAT_W / 8;

  ovi_pkg::stride_t el_bytes;
  logic             stride_hit;
  logic             stride_neg;
  logic [1:0]       ratio_log2;
  logic [1:0]       off;

  assign el_bytes = ovi_pkg::stride_t'(1) << i_eew;

  // stride as a signed multiple of 1, 2 or 4 elements
  always_comb begin
    stride_hit = 1'b1;
    stride_neg = 1'b0;
    ratio_log2 = 2'd0;
    if (i_stride == el_bytes) begin
      ratio_log2 = 2'd0;
    end else if (i_stride == -el_bytes) begin
      stride_neg = 1'b1;
    end else if (i_stride == (el_bytes << 1)) begin
      ratio_log2 = 2'd1;
    end else if (i_stride == -(el_bytes << 1)) begin
      stride_neg = 1'b1;
      ratio_log2 = 2'd1;
    end else if (i_stride == (el_bytes << 2)) begin
      ratio_log2 = 2'd2;
    end else if (i_stride == -(el_bytes << 2)) begin
      stride_neg = 1'b1;
      ratio_log2 = 2'd2;
    end else begin
      stride_hit = 1'b0;
    end
  end

  // el_off mod r picks the lane inside each group of r elements
  assign off = 2'(i_el_off & ((6'd1 << ratio_log2) - 6'd1));

  // byte-wise gather, each packed byte finds its source element
  always_comb begin
    int unsigned n_el;
    int unsigned el;
    int unsigned byte_sel;
    int unsigned src_el;
    n_el     = BEAT_BYTES >> i_eew;
    el       = 0;
    byte_sel = 0;
    src_el   = 0;
    o_packed = i_load_data;
    if (stride_hit) begin
      o_packed = '0;
      for (int k = 0; k < BEAT_BYTES; k++) begin
        el       = k >> i_eew;
        byte_sel = k & ((1 << i_eew) - 1);
        // elements past N/r stay zero
        if (el < (n_el >> ratio_log2)) begin
          if (stride_neg)
            src_el = n_el - 1 - (el << ratio_log2) - off;
          else
            src_el = (el << ratio_log2) + off;
          o_packed[k*8 +: 8] = i_load_data[((src_el << i_eew) + byte_sel)*8 +: 8];
        end
      end
    end
  end

endmodule

//--- rtl/ovi_memop_ctrl.sv
`timescale 1ns/100ps

module ovi_memop_ctrl (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             i_issue_valid,
  input  logic [31:0]      i_issue_inst,
  input  ovi_pkg::sb_id_t  i_issue_sb_id,
  input  ovi_pkg::stride_t i_issue_scalar_opnd,
  input  logic             i_memop_sync_end,
  input  logic             i_drained,
  output logic             o_issue_ready,
  output logic             o_memop_sync_start,
  output logic             o_completed_valid,
  output ovi_pkg::sb_id_t  o_completed_sb_id,
  output ovi_pkg::eew_t    o_eew,
  output ovi_pkg::stride_t o_stride
);

  ovi_pkg::memop_state_t state;
  ovi_pkg::eew_t         eew_dec;
  ovi_pkg::sb_id_t       sb_id_q;
  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic                  is_memop;
  logic                  accept;
  logic                  is_store;
  logic                  done;

  assign opcode   = i_issue_inst[6:0];
  assign funct3   = i_issue_inst[14:12];
  assign is_memop = (opcode == ovi_pkg::OPC_VLOAD) || (opcode == ovi_pkg::OPC_VSTORE);

  // one memory op at a time
  assign o_issue_ready = (state == ovi_pkg::MEMOP_IDLE);
  assign accept        = i_issue_valid && o_issue_ready && is_memop;

  always_comb begin
    case (funct3)
      ovi_pkg::WIDTH_E8:  eew_dec = 2'd0;
      ovi_pkg::WIDTH_E16: eew_dec = 2'd1;
      ovi_pkg::WIDTH_E32: eew_dec = 2'd2;
      default:            eew_dec = 2'd3;
    endcase
  end

  // loads finish on sync end, stores also need an empty store buffer
  always_comb begin
    case (state)
      ovi_pkg::MEMOP_ACTIVE: done = i_memop_sync_end && (!is_store || i_drained);
      ovi_pkg::MEMOP_DRAIN:  done = i_drained;
      default:               done = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state              <= ovi_pkg::MEMOP_IDLE;
      o_memop_sync_start <= 1'b0;
      o_completed_valid  <= 1'b0;
    end else begin
      o_memop_sync_start <= accept;
      o_completed_valid  <= done;
      case (state)
        ovi_pkg::MEMOP_IDLE: begin
          if (accept)
            state <= ovi_pkg::MEMOP_ACTIVE;
        end
        ovi_pkg::MEMOP_ACTIVE: begin
          if (done)
            state <= ovi_pkg::MEMOP_IDLE;
          else if (i_memop_sync_end)
            state <= ovi_pkg::MEMOP_DRAIN;
        end
        ovi_pkg::MEMOP_DRAIN: begin
          if (done)
            state <= ovi_pkg::MEMOP_IDLE;
        end
        default: state <= ovi_pkg::MEMOP_IDLE;
      endcase
    end
  end

  // op attributes, held until the next accepted issue
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      is_store <= 1'b0;
      o_eew    <= '0;
      o_stride <= '0;
    end else if (accept) begin
      is_store <= (opcode == ovi_pkg::OPC_VSTORE);
      o_eew    <= eew_dec;
      o_stride <= i_issue_scalar_opnd;
    end
  end

  always_ff @(posedge clk) begin
    if (accept)
      sb_id_q <= i_issue_sb_id;
  end

  assign o_completed_sb_id = sb_id_q;

endmodule

//--- rtl/ovi_pkg.sv
package ovi_pkg;

  // data path widths
  localparam int VLEN      = 256;
  localparam int BEAT_W    = 512;
  localparam int NUM_VREGS = 8;

  localparam int SEQ_ID_W  = 34;
  localparam int SB_ID_W   = 5;
  localparam int STRIDE_W  = 64;

  typedef logic [VLEN-1:0]     vreg_t;
  typedef logic [BEAT_W-1:0]   beat_t;
  typedef logic [SEQ_ID_W-1:0] seq_id_t;
  typedef logic [SB_ID_W-1:0]  sb_id_t;
  typedef logic [2:0]          vreg_idx_t;
  typedef logic [10:0]         el_idx_t;
  typedef logic [5:0]          el_off_t;
  typedef logic [6:0]          el_cnt_t;
  typedef logic [STRIDE_W-1:0] stride_t;

  // 0..3 select 8, 16, 32 and 64 bit elements
  typedef logic [1:0]          eew_t;

  // load sequence id fields, sb id at bit 29 is not used here
  localparam int SEQ_VREG_LSB  = 0;
  localparam int SEQ_ELID_LSB  = 5;
  localparam int SEQ_ELOFF_LSB = 16;
  localparam int SEQ_ELCNT_LSB = 22;

  // major opcodes of vector loads and stores
  localparam logic [6:0] OPC_VLOAD  = 7'b0000111;
  localparam logic [6:0] OPC_VSTORE = 7'b0100111;

  // funct3 width codes, anything else is 64 bit
  localparam logic [2:0] WIDTH_E8  = 3'b000;
  localparam logic [2:0] WIDTH_E16 = 3'b101;
  localparam logic [2:0] WIDTH_E32 = 3'b110;

  typedef enum logic [1:0] {
    MEMOP_IDLE,
    MEMOP_ACTIVE,
    MEMOP_DRAIN
  } memop_state_t;

endpackage
